/* bench/icache_bus_asserts.sv */
`timescale 1ns/1ps

module icache_bus_asserts (
  input logic                              clk_i,
  input logic                              rst_ni,
  input logic                              fetch_req_i,
  input logic                              fetch_ack_o,
  input logic                              ar_valid_o,
  input logic                              ar_ready_i,
  input logic [icache_pkg::ADDR_WIDTH-1:0] ar_addr_o,
  input logic [icache_pkg::BLEN_WIDTH-1:0] ar_len_o
);

  int unsigned fail_cnt = 0;

  // Read request and its fields hold until the grant
  property p_ar_stable;
    @(posedge clk_i) disable iff (!rst_ni)
      ar_valid_o && !ar_ready_i |=> ar_valid_o && $stable(ar_addr_o) && $stable(ar_len_o);
  endproperty

  // Ack returns to zero only after the request has dropped
  property p_ack_fall;
    @(posedge clk_i) disable iff (!rst_ni)
      $fell(fetch_ack_o) |-> !$past(fetch_req_i);
  endproperty

  property p_reset_idle;
    @(posedge clk_i) $rose(rst_ni) |-> !fetch_ack_o && !ar_valid_o;
  endproperty

  a_ar_stable: assert property (p_ar_stable)
    else begin
      $error("read address channel changed before ar_ready_i");
      fail_cnt++;
    end
  a_ack_fall: assert property (p_ack_fall)
    else begin
      $error("fetch_ack_o fell while fetch_req_i was high");
      fail_cnt++;
    end
  a_reset_idle: assert property (p_reset_idle)
    else begin
      $error("fetch_ack_o or ar_valid_o high after reset");
      fail_cnt++;
    end

endmodule

bind icache_bus_top icache_bus_asserts i_icache_bus_asserts (
  .clk_i       (clk_i),
  .rst_ni      (rst_ni),
  .fetch_req_i (fetch_req_i),
  .fetch_ack_o (fetch_ack_o),
  .ar_valid_o  (ar_valid_o),
  .ar_ready_i  (ar_ready_i),
  .ar_addr_o   (ar_addr_o),
  .ar_len_o    (ar_len_o)
);

/* bench/icache_bus_tb.sv */
`timescale 1ns/1ps

module icache_bus_tb;
  import icache_pkg::*;

  localparam int unsigned           TIMEOUT_CYCLES = 200;
  localparam logic [WORD_WIDTH-1:0] DATA_XOR       = 32'h5a5a_0000;

  logic                  clk_i;
  logic                  rst_ni;
  logic                  flush_i;
  logic                  en_i;
  logic                  fetch_req_i;
  logic [ADDR_WIDTH-1:0] fetch_addr_i;
  logic                  fetch_ack_o;
  logic [WORD_WIDTH-1:0] fetch_rdata_o;
  logic                  miss_o;
  logic                  ar_valid_o;
  logic                  ar_ready_i;
  logic [ADDR_WIDTH-1:0] ar_addr_o;
  logic [BLEN_WIDTH-1:0] ar_len_o;
  logic                  r_valid_i;
  logic                  r_last_i;
  logic [WORD_WIDTH-1:0] r_data_i;

  integer      seed     = 32'heb01;
  int unsigned miss_cnt = 0;
  int unsigned exp_miss = 0;
  int unsigned ar_cnt   = 0;

  // Last read request granted by the memory model
  logic [ADDR_WIDTH-1:0] ar_addr_seen;
  logic [BLEN_WIDTH-1:0] ar_len_seen;

  // Reference model of the cache contents
  logic                ref_valid [NUM_SETS];
  logic [TAG_BITS-1:0] ref_tag   [NUM_SETS];

  icache_bus_top i_dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  always @(negedge clk_i) begin
    if (rst_ni === 1'b1 && miss_o === 1'b1) begin
      miss_cnt++;
    end
  end

  always @(negedge clk_i) begin
    if (i_dut.i_icache_bus_asserts.fail_cnt != 0) begin
      $display("a protocol assertion on the DUT ports failed");
      fail_stop();
    end
  end

  // Memory model with random grant delay and beat gaps
  initial begin : mem_model
    logic [ADDR_WIDTH-1:0] base;
    int unsigned           beats;
    ar_ready_i = 1'b0;
    r_valid_i  = 1'b0;
    r_last_i   = 1'b0;
    r_data_i   = '0;
    forever begin
      @(negedge clk_i);
      if (rst_ni === 1'b1 && ar_valid_o === 1'b1) begin
        base         = ar_addr_o;
        beats        = ar_len_o + 1;
        ar_addr_seen = ar_addr_o;
        ar_len_seen  = ar_len_o;
        repeat ($unsigned($random(seed)) % 4) @(posedge clk_i);
        @(posedge clk_i);
        ar_ready_i <= 1'b1;
        @(posedge clk_i);
        ar_ready_i <= 1'b0;
        ar_cnt++;
        for (int i = 0; i < beats; i++) begin
          repeat ($unsigned($random(seed)) % 3) begin
            @(posedge clk_i);
            r_valid_i <= 1'b0;
          end
          @(posedge clk_i);
          r_valid_i <= 1'b1;
          r_data_i  <= (base + 4 * i) ^ DATA_XOR;
          r_last_i  <= (i == beats - 1);
        end
        @(posedge clk_i);
        r_valid_i <= 1'b0;
        r_last_i  <= 1'b0;
      end
    end
  end

  task automatic fail_stop;
    $display("Checks failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_eq(input logic [31:0] actual, input logic [31:0] expected,
                          input string what);
    if (actual !== expected) begin
      $display("error at %0t: %s is %h, expected %h", $time, what, actual, expected);
      fail_stop();
    end
  endtask

  task automatic timeout_fail(input string what);
    $display("timeout while waiting for %s", what);
    fail_stop();
  endtask

  task automatic set_enable(input logic value);
    @(posedge clk_i);
    en_i <= value;
    @(negedge clk_i);
  endtask

  task automatic flush_cache;
    @(posedge clk_i);
    flush_i <= 1'b1;
    @(posedge clk_i);
    flush_i <= 1'b0;
    foreach (ref_valid[s]) ref_valid[s] = 1'b0;
  endtask

  // One four-phase access checked against the reference model
  task automatic fetch(input logic [ADDR_WIDTH-1:0] addr);
    logic                  nc;
    logic                  hit;
    logic [INDEX_BITS-1:0] idx;
    logic [TAG_BITS-1:0]   tag;
    logic [ADDR_WIDTH-1:0] word_addr;
    int unsigned           edges;
    int unsigned           ar_before;
    nc        = addr[NC_BIT] | ~en_i;
    idx       = addr[OFFSET_BITS+2 +: INDEX_BITS];
    tag       = addr[NC_BIT-1 -: TAG_BITS];
    hit       = !nc && ref_valid[idx] && (ref_tag[idx] == tag);
    word_addr = {addr[ADDR_WIDTH-1:2], 2'b00};
    ar_before = ar_cnt;
    @(posedge clk_i);
    fetch_req_i  <= 1'b1;
    fetch_addr_i <= addr;
    edges = 0;
    do begin
      @(posedge clk_i);
      edges++;
      @(negedge clk_i);
    end while (!fetch_ack_o && edges < TIMEOUT_CYCLES);
    if (!fetch_ack_o) timeout_fail("fetch_ack_o to rise");
    check_eq(fetch_rdata_o, word_addr ^ DATA_XOR, "fetch_rdata_o");
    if (hit) begin
      check_eq(edges, 2, "hit latency in edges");
      check_eq(ar_cnt, ar_before, "bus requests on a hit");
    end else begin
      exp_miss++;
      check_eq(ar_cnt, ar_before + 1, "bus requests on a miss");
      check_eq(ar_len_seen, nc ? 0 : LINE_WORDS - 1, "ar_len_o");
      check_eq(ar_addr_seen, nc ? word_addr : {addr[ADDR_WIDTH-1:4], 4'h0}, "ar_addr_o");
      if (!nc) begin
        ref_valid[idx] = 1'b1;
        ref_tag[idx]   = tag;
      end
    end
    check_eq(miss_cnt, exp_miss, "miss_o pulse count");
    @(posedge clk_i);
    fetch_req_i <= 1'b0;
    edges = 0;
    do begin
      @(posedge clk_i);
      edges++;
      @(negedge clk_i);
    end while (fetch_ack_o && edges < TIMEOUT_CYCLES);
    if (fetch_ack_o) timeout_fail("fetch_ack_o to fall");
  endtask

  task automatic cold_miss_then_hits;
    fetch(32'h0000_1238);
    for (int w = 0; w < LINE_WORDS; w++) begin
      fetch(32'h0000_1230 + 4 * w);
    end
  endtask

  task automatic burst_len_and_align;
    fetch(32'h0004_567c);
    fetch(32'h0004_5674);
  endtask

  task automatic bypass_accesses;
    fetch(32'h8000_0104);
    fetch(32'h8000_0104);
    set_enable(1'b0);
    fetch(32'h0000_1234);
    fetch(32'h0000_1234);
    set_enable(1'b1);
    // Line from the first test must still be there
    fetch(32'h0000_1234);
  endtask

  task automatic conflict_and_flush;
    fetch(32'h0001_0050);
    fetch(32'h0002_0058);
    fetch(32'h0001_0054);
    fetch(32'h0001_005c);
    flush_cache();
    fetch(32'h0001_0050);
  endtask

  task automatic random_traffic;
    logic [ADDR_WIDTH-1:0] addr;
    for (int i = 0; i < 40; i++) begin
      addr = $random(seed);
      // Few tags so that hits and conflicts both occur
      addr[NC_BIT-1 -: TAG_BITS] = TAG_BITS'($unsigned($random(seed)) % 3);
      addr[NC_BIT] = ($unsigned($random(seed)) % 5) == 0;
      addr[1:0]    = 2'b00;
      fetch(addr);
    end
    check_eq(miss_cnt, exp_miss, "miss_o pulses after random traffic");
  endtask

  initial begin
    rst_ni       = 1'b0;
    flush_i      = 1'b0;
    en_i         = 1'b1;
    fetch_req_i  = 1'b0;
    fetch_addr_i = '0;
    foreach (ref_valid[s]) ref_valid[s] = 1'b0;
    repeat (16) @(posedge clk_i);
    rst_ni <= 1'b1;
    cold_miss_then_hits();
    burst_len_and_align();
    bypass_accesses();
    conflict_and_flush();
    random_traffic();
    if (i_dut.i_icache_bus_asserts.fail_cnt == 0) begin
      $display("All checks passed");
      $finish;
    end else begin
      $display("a protocol assertion on the DUT ports failed");
      fail_stop();
    end
  end

endmodule

/* sim.f */
verilog/icache_pkg.sv
verilog/refill_req_hold.sv
verilog/refill_beat_collect.sv
verilog/icache_ctrl.sv
verilog/icache_bus_top.sv
bench/icache_bus_asserts.sv
bench/icache_bus_tb.sv

/* verilog/icache_bus_top.sv */
`timescale 1ns/1ps

module icache_bus_top (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              flush_i,
  input  logic                              en_i,
  // Fetch side, four-phase req/ack
  input  logic                              fetch_req_i,
  input  logic [icache_pkg::ADDR_WIDTH-1:0] fetch_addr_i,
  output logic                              fetch_ack_o,
  output logic [icache_pkg::WORD_WIDTH-1:0] fetch_rdata_o,
  output logic                              miss_o,
  // Bus read address channel
  output logic                              ar_valid_o,
  input  logic                              ar_ready_i,
  output logic [icache_pkg::ADDR_WIDTH-1:0] ar_addr_o,
  output logic [icache_pkg::BLEN_WIDTH-1:0] ar_len_o,
  // Bus read data channel, always accepted
  input  logic                              r_valid_i,
  input  logic                              r_last_i,
  input  logic [icache_pkg::WORD_WIDTH-1:0] r_data_i
);
  import icache_pkg::*;

  logic                  refill_req;
  logic [ADDR_WIDTH-1:0] refill_addr;
  logic                  refill_nc;
  logic                  line_valid;
  logic [LINE_WIDTH-1:0] line_data;

  icache_ctrl i_icache_ctrl (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .flush_i       (flush_i),
    .en_i          (en_i),
    .fetch_req_i   (fetch_req_i),
    .fetch_addr_i  (fetch_addr_i),
    .fetch_ack_o   (fetch_ack_o),
    .fetch_rdata_o (fetch_rdata_o),
    .miss_o        (miss_o),
    .refill_req_o  (refill_req),
    .refill_addr_o (refill_addr),
    .refill_nc_o   (refill_nc),
    .line_valid_i  (line_valid),
    .line_data_i   (line_data)
  );

  // Turns the one-cycle refill pulse into a stable bus request
  refill_req_hold i_refill_req_hold (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .refill_req_i  (refill_req),
    .refill_addr_i (refill_addr),
    .refill_nc_i   (refill_nc),
    .ar_valid_o    (ar_valid_o),
    .ar_ready_i    (ar_ready_i),
    .ar_addr_o     (ar_addr_o),
    .ar_len_o      (ar_len_o)
  );

  refill_beat_collect i_refill_beat_collect (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .r_valid_i    (r_valid_i),
    .r_last_i     (r_last_i),
    .r_data_i     (r_data_i),
    .line_valid_o (line_valid),
    .line_data_o  (line_data)
  );

endmodule

/* verilog/icache_ctrl.sv */
`timescale 1ns/1ps

module icache_ctrl (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              flush_i,
  input  logic                              en_i,
  input  logic                              fetch_req_i,
  input  logic [icache_pkg::ADDR_WIDTH-1:0] fetch_addr_i,
  output logic                              fetch_ack_o,
  output logic [icache_pkg::WORD_WIDTH-1:0] fetch_rdata_o,
  output logic                              miss_o,
  output logic                              refill_req_o,
  output logic [icache_pkg::ADDR_WIDTH-1:0] refill_addr_o,
  output logic                              refill_nc_o,
  input  logic                              line_valid_i,
  input  logic [icache_pkg::LINE_WIDTH-1:0] line_data_i
);
  import icache_pkg::*;

  ic_state_e             state_q;
  logic [ADDR_WIDTH-1:0] addr_q;

  // Cache arrays
  logic [NUM_SETS-1:0]   valid_q;
  logic [TAG_BITS-1:0]   tag_q  [NUM_SETS];
  logic [LINE_WIDTH-1:0] data_q [NUM_SETS];

  // Fields of the latched fetch address
  logic [OFFSET_BITS-1:0] off;
  logic [INDEX_BITS-1:0]  idx;
  logic [TAG_BITS-1:0]    tag;
  logic                   nc;
  logic                   hit;
  logic [LINE_WIDTH-1:0]  hit_line;

  assign off = addr_q[OFFSET_BITS+1:2];
  assign idx = addr_q[INDEX_BITS+OFFSET_BITS+1:OFFSET_BITS+2];
  assign tag = addr_q[NC_BIT-1:NC_BIT-TAG_BITS];

  // Everything is bypassed while the cache is disabled
  assign nc = addr_q[NC_BIT] | ~en_i;

  assign hit      = ~nc & valid_q[idx] & (tag_q[idx] == tag);
  assign hit_line = data_q[idx];

  // FSM and valid bits
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= IC_IDLE;
      valid_q      <= '0;
      fetch_ack_o  <= 1'b0;
      miss_o       <= 1'b0;
      refill_req_o <= 1'b0;
      refill_nc_o  <= 1'b0;
    end else begin
      // Single-cycle pulses by default
      miss_o       <= 1'b0;
      refill_req_o <= 1'b0;

      unique case (state_q)
        IC_IDLE: begin
          // Flush wins over a new request in the same cycle
          if (flush_i) begin
            valid_q <= '0;
          end else if (fetch_req_i) begin
            state_q <= IC_LOOKUP;
          end
        end

        IC_LOOKUP: begin
          if (hit) begin
            fetch_ack_o <= 1'b1;
            state_q     <= IC_DONE;
          end else begin
            miss_o       <= 1'b1;
            refill_req_o <= 1'b1;
            refill_nc_o  <= nc;
            state_q      <= IC_REFILL;
          end
        end

        IC_REFILL: begin
          if (line_valid_i) begin
            if (!refill_nc_o) begin
              valid_q[idx] <= 1'b1;
            end
            fetch_ack_o <= 1'b1;
            state_q     <= IC_DONE;
          end
        end

        IC_DONE: begin
          // Four-phase return to zero
          if (!fetch_req_i) begin
            fetch_ack_o <= 1'b0;
            state_q     <= IC_IDLE;
          end
        end

        default: state_q <= IC_IDLE;
      endcase
    end
  end

  // Address latch, tag and data arrays, read data
  always_ff @(posedge clk_i) begin
    if (state_q == IC_IDLE) begin
      addr_q <= fetch_addr_i;
    end

    if (state_q == IC_LOOKUP) begin
      if (hit) begin
        fetch_rdata_o <= hit_line[off*WORD_WIDTH +: WORD_WIDTH];
      end
      // Word address for a bypass, line-aligned address for a refill
      if (nc) begin
        refill_addr_o <= {addr_q[ADDR_WIDTH-1:2], 2'b00};
      end else begin
        refill_addr_o <= {addr_q[ADDR_WIDTH-1:OFFSET_BITS+2], {(OFFSET_BITS+2){1'b0}}};
      end
    end

    if (state_q == IC_REFILL && line_valid_i) begin
      if (refill_nc_o) begin
        // Single beat sits at word 0
        fetch_rdata_o <= line_data_i[WORD_WIDTH-1:0];
      end else begin
        fetch_rdata_o <= line_data_i[off*WORD_WIDTH +: WORD_WIDTH];
        data_q[idx]   <= line_data_i;
        tag_q[idx]    <= tag;
      end
    end
  end

endmodule

/* verilog/icache_pkg.sv */
package icache_pkg;

  // Address and data widths on the fetch side and the bus
  localparam int unsigned ADDR_WIDTH = 32;
  localparam int unsigned WORD_WIDTH = 32;

  // Line geometry
  localparam int unsigned LINE_WIDTH = 128;
  localparam int unsigned LINE_WORDS = LINE_WIDTH / WORD_WIDTH;
  localparam int unsigned NUM_SETS   = 16;

  // Address split: tag [30:8], index [7:4], word offset [3:2]
  localparam int unsigned INDEX_BITS  = 4;
  localparam int unsigned OFFSET_BITS = 2;
  localparam int unsigned TAG_BITS    = 23;

  // Burst length field holds beats minus one
  localparam int unsigned BLEN_WIDTH = 2;

  // Addresses with this bit set bypass the cache
  localparam int unsigned NC_BIT = 31;

  // Controller states
  typedef enum logic [1:0] {
    IC_IDLE,
    IC_LOOKUP,
    IC_REFILL,
    IC_DONE
  } ic_state_e;

endpackage

/* verilog/refill_beat_collect.sv */
`timescale 1ns/1ps

module refill_beat_collect (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              r_valid_i,
  input  logic                              r_last_i,
  input  logic [icache_pkg::WORD_WIDTH-1:0] r_data_i,
  output logic                              line_valid_o,
  output logic [icache_pkg::LINE_WIDTH-1:0] line_data_o
);
  import icache_pkg::*;

  logic                                  first_q;
  logic [LINE_WORDS-1:0][WORD_WIDTH-1:0] shift_q;
  logic [LINE_WORDS-1:0][WORD_WIDTH-1:0] shift_d;

  // Beats enter at the top and move down toward word 0
  always_comb begin
    shift_d = shift_q;
    if (r_valid_i) begin
      shift_d = {r_data_i, shift_q[LINE_WORDS-1:1]};
      // A lone beat has to land at word 0
      if (first_q) begin
        shift_d[0] = r_data_i;
      end
    end
  end

  // Line is complete together with the last beat
  assign line_valid_o = r_valid_i & r_last_i;
  assign line_data_o  = shift_d;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      first_q <= 1'b1;
    end else if (r_valid_i) begin
      first_q <= r_last_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (r_valid_i) begin
      shift_q <= shift_d;
    end
  end

endmodule

/* verilog/refill_req_hold.sv */
`timescale 1ns/1ps

module refill_req_hold (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              refill_req_i,
  input  logic [icache_pkg::ADDR_WIDTH-1:0] refill_addr_i,
  input  logic                              refill_nc_i,
  output logic                              ar_valid_o,
  input  logic                              ar_ready_i,
  output logic [icache_pkg::ADDR_WIDTH-1:0] ar_addr_o,
  output logic [icache_pkg::BLEN_WIDTH-1:0] ar_len_o
);
  import icache_pkg::*;

  logic                  pending_q;
  logic [ADDR_WIDTH-1:0] addr_q;
  logic                  nc_q;
  logic                  nc;

  // New pulse or a request still waiting for its grant
  assign ar_valid_o = refill_req_i | pending_q;
  assign ar_addr_o  = refill_req_i ? refill_addr_i : addr_q;
  assign nc         = refill_req_i ? refill_nc_i : nc_q;

  // One beat for a bypass, a whole line otherwise
  assign ar_len_o = nc ? '0 : BLEN_WIDTH'(LINE_WORDS - 1);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pending_q <= 1'b0;
    end else begin
      pending_q <= ar_valid_o & ~ar_ready_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (refill_req_i) begin
      addr_q <= refill_addr_i;
      nc_q   <= refill_nc_i;
    end
  end

endmodule
